/* source/periph_pkg.sv */
// Peripheral subsystem package
// Bus widths, address map, bridge states and timer register selector
`default_nettype none

package periph_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;

    typedef logic [addr_width-1:0] reg_addr_t;
    typedef logic [data_width-1:0] reg_data_t;

    // ------------------------------
    // Address map
    // ------------------------------
    // Region code sits in address bits 15:12
    localparam int region_lsb = 12;
    localparam int region_msb = 15;

    localparam logic [region_msb-region_lsb:0] region_timer = 4'd0;
    localparam logic [region_msb-region_lsb:0] region_plic  = 4'd1;

    // Read data of the unmapped region
    localparam reg_data_t error_word = 32'hDEAD_BEEF;

    // APB bridge FSM
    typedef enum logic {
        IDLE,
        RESP
    } bridge_state_e;

    // Timer registers, selected by address bits 3:2
    typedef enum logic [1:0] {
        TMR_CTRL   = 2'd0,
        TMR_COUNT  = 2'd1,
        TMR_CMP    = 2'd2,
        TMR_STATUS = 2'd3
    } timer_reg_e;

    localparam int timer_sel_bit = 4;
    localparam int num_timers    = 2;

endpackage

`default_nettype wire

/* source/irq_pkg.sv */
// Interrupt package
// Source, target and priority sizes, PLIC register offsets
`default_nettype none

package irq_pkg;

    // Source ids run from 1, id 0 means no source
    localparam int num_sources = 2;
    localparam int num_targets = 2;
    localparam int prio_width  = 3;

    typedef logic [prio_width-1:0] prio_t;
    typedef logic [1:0]            src_id_t;

    // ------------------------------
    // Offsets inside the PLIC region
    // ------------------------------
    // Priority of source s at base + 4*s
    localparam logic [11:0] plic_prio_base     = 12'h000;
    // Enable mask of target t at base + 4*t
    localparam logic [11:0] plic_enable_base   = 12'h080;
    // Threshold at +0, claim/complete at +4 per target
    localparam logic [11:0] plic_target_base   = 12'h100;
    localparam logic [11:0] plic_target_stride = 12'h010;

endpackage

`default_nettype wire

/* source/reg_bus_if.sv */
// Register bus
// Single-cycle request with a combinational response, no ready
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

    logic                  valid;
    logic                  write;
    periph_pkg::reg_addr_t addr;
    periph_pkg::reg_data_t wdata;
    periph_pkg::reg_data_t rdata;
    logic                  error;

    // Initiator side
    modport master (
        output valid, write, addr, wdata,
        input  rdata, error
    );

    // Responder answers in the same cycle
    modport slave (
        input  valid, write, addr, wdata,
        output rdata, error
    );

endinterface

`default_nettype wire

/* source/apb_reg_bridge.sv */
// APB to register bus bridge
// Issues one register request per APB transfer and holds the
// response in registers for the completion cycle
`timescale 1ns/1ps
`default_nettype none

module apb_reg_bridge (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  periph_pkg::reg_addr_t paddr_i,
    input  periph_pkg::reg_data_t pwdata_i,
    output periph_pkg::reg_data_t prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    reg_bus_if.master             bus_o
);

    periph_pkg::bridge_state_e state_q;
    periph_pkg::bridge_state_e state_d;
    periph_pkg::reg_data_t     rdata_q;
    logic                      err_q;

    // Request only in the first access cycle
    assign bus_o.valid = psel_i & penable_i & (state_q == periph_pkg::IDLE);
    assign bus_o.write = pwrite_i;
    assign bus_o.addr  = paddr_i;
    assign bus_o.wdata = pwdata_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            periph_pkg::IDLE: begin
                if (bus_o.valid) begin
                    state_d = periph_pkg::RESP;
                end
            end
            periph_pkg::RESP: state_d = periph_pkg::IDLE;
            default: state_d = periph_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= periph_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Response capture
    always_ff @(posedge clk_i) begin
        if (bus_o.valid) begin
            rdata_q <= bus_o.rdata;
            err_q   <= bus_o.error;
        end
    end

    assign pready_o  = (state_q == periph_pkg::RESP);
    assign pslverr_o = pready_o & err_q;
    assign prdata_o  = rdata_q;

endmodule

`default_nettype wire

/* source/reg_decoder.sv */
// Register bus decoder
// Routes each request to the timer or the PLIC by address region,
// anything else gets an error response
`timescale 1ns/1ps
`default_nettype none

module reg_decoder (
    reg_bus_if.slave  bus_i,
    reg_bus_if.master tmr_o,
    reg_bus_if.master plic_o
);

    logic [periph_pkg::region_msb-periph_pkg::region_lsb:0] region;
    logic                                                  hit_tmr;
    logic                                                  hit_plic;

    assign region   = bus_i.addr[periph_pkg::region_msb:periph_pkg::region_lsb];
    assign hit_tmr  = (region == periph_pkg::region_timer);
    assign hit_plic = (region == periph_pkg::region_plic);

    // ------------------------------
    // Request fan-out
    // ------------------------------
    assign tmr_o.valid = bus_i.valid & hit_tmr;
    assign tmr_o.write = bus_i.write;
    assign tmr_o.addr  = bus_i.addr;
    assign tmr_o.wdata = bus_i.wdata;

    assign plic_o.valid = bus_i.valid & hit_plic;
    assign plic_o.write = bus_i.write;
    assign plic_o.addr  = bus_i.addr;
    assign plic_o.wdata = bus_i.wdata;

    // ------------------------------
    // Response mux
    // ------------------------------
    always_comb begin
        if (hit_tmr) begin
            bus_i.rdata = tmr_o.rdata;
            bus_i.error = tmr_o.error;
        end else if (hit_plic) begin
            bus_i.rdata = plic_o.rdata;
            bus_i.error = plic_o.error;
        end else begin
            // Unmapped, write goes nowhere
            bus_i.rdata = periph_pkg::error_word;
            bus_i.error = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/timer_unit.sv */
// Compare timer unit
// Free-running counters that wrap on compare match and raise a
// sticky pending flag, gated by a per-channel irq enable
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
    input  logic                              clk_i,
    input  logic                              rst_i,
    reg_bus_if.slave                          bus_i,
    output logic [periph_pkg::num_timers-1:0] irq_src_o
);

    logic [periph_pkg::num_timers-1:0] en_q;
    logic [periph_pkg::num_timers-1:0] irq_en_q;
    logic [periph_pkg::num_timers-1:0] pend_q;
    logic [periph_pkg::num_timers-1:0] match;
    periph_pkg::reg_data_t             count_q [periph_pkg::num_timers];
    periph_pkg::reg_data_t             cmp_q   [periph_pkg::num_timers];
    periph_pkg::timer_reg_e            reg_sel;
    logic                              ch;
    logic                              wr;

    assign reg_sel = periph_pkg::timer_reg_e'(bus_i.addr[3:2]);
    assign ch      = bus_i.addr[periph_pkg::timer_sel_bit];
    assign wr      = bus_i.valid & bus_i.write;

    always_comb begin
        for (int i = 0; i < periph_pkg::num_timers; i++) begin
            match[i]     = en_q[i] & (count_q[i] == cmp_q[i]);
            irq_src_o[i] = pend_q[i] & irq_en_q[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q     <= '0;
            irq_en_q <= '0;
            pend_q   <= '0;
            for (int i = 0; i < periph_pkg::num_timers; i++) begin
                count_q[i] <= '0;
                cmp_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < periph_pkg::num_timers; i++) begin
                // Counting, a register write below takes precedence
                if (match[i]) begin
                    count_q[i] <= '0;
                    pend_q[i]  <= 1'b1;
                end else if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 32'd1;
                end
                if (wr && int'(ch) == i) begin
                    unique case (reg_sel)
                        periph_pkg::TMR_CTRL: begin
                            en_q[i]     <= bus_i.wdata[0];
                            irq_en_q[i] <= bus_i.wdata[1];
                        end
                        periph_pkg::TMR_COUNT: count_q[i] <= bus_i.wdata;
                        periph_pkg::TMR_CMP:   cmp_q[i]   <= bus_i.wdata;
                        // Write 1 to clear, a match in the same cycle wins
                        periph_pkg::TMR_STATUS: begin
                            if (bus_i.wdata[0] && !match[i]) begin
                                pend_q[i] <= 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Read mux
    always_comb begin
        unique case (reg_sel)
            periph_pkg::TMR_CTRL:   bus_i.rdata = {30'd0, irq_en_q[ch], en_q[ch]};
            periph_pkg::TMR_COUNT:  bus_i.rdata = count_q[ch];
            periph_pkg::TMR_CMP:    bus_i.rdata = cmp_q[ch];
            periph_pkg::TMR_STATUS: bus_i.rdata = {31'd0, pend_q[ch]};
            default:                bus_i.rdata = '0;
        endcase
    end

    assign bus_i.error = 1'b0;

endmodule

`default_nettype wire

/* source/plic_core.sv */
// Platform-level interrupt controller
// Level gateways, per-source priority, per-target enable and
// threshold, claim/complete handshake and registered target lines
`timescale 1ns/1ps
`default_nettype none

module plic_core (
    input  logic                            clk_i,
    input  logic                            rst_i,
    reg_bus_if.slave                        bus_i,
    input  logic [irq_pkg::num_sources-1:0] irq_src_i,
    output logic [irq_pkg::num_targets-1:0] irq_o
);

    irq_pkg::prio_t                  prio_q      [1:irq_pkg::num_sources];
    logic [irq_pkg::num_sources:1]   enable_q    [irq_pkg::num_targets];
    irq_pkg::prio_t                  threshold_q [irq_pkg::num_targets];
    logic [irq_pkg::num_sources:1]   pending_q;
    logic [irq_pkg::num_sources:1]   inflight_q;
    logic [irq_pkg::num_sources:1]   src_lvl;
    logic [irq_pkg::num_sources:1]   claim_mask;
    logic [irq_pkg::num_sources:1]   complete_mask;
    irq_pkg::src_id_t                best_id     [irq_pkg::num_targets];
    irq_pkg::prio_t                  best_prio   [irq_pkg::num_targets];
    logic [irq_pkg::num_targets-1:0] irq_d;
    logic [11:0]                     offs;
    logic                            rd;
    logic                            wr;

    assign src_lvl = irq_src_i;
    assign offs    = bus_i.addr[11:0];
    assign rd      = bus_i.valid & ~bus_i.write;
    assign wr      = bus_i.valid & bus_i.write;

    // ------------------------------
    // Per-target arbitration
    // ------------------------------
    // Strict compare keeps the lowest id on ties
    always_comb begin
        for (int t = 0; t < irq_pkg::num_targets; t++) begin
            best_id[t]   = '0;
            best_prio[t] = threshold_q[t];
            for (int s = 1; s <= irq_pkg::num_sources; s++) begin
                if (pending_q[s] && enable_q[t][s] && prio_q[s] > best_prio[t]) begin
                    best_id[t]   = irq_pkg::src_id_t'(s);
                    best_prio[t] = prio_q[s];
                end
            end
            irq_d[t] = (best_id[t] != '0);
        end
    end

    // ------------------------------
    // Register access
    // ------------------------------
    always_comb begin
        bus_i.rdata   = '0;
        claim_mask    = '0;
        complete_mask = '0;
        for (int s = 1; s <= irq_pkg::num_sources; s++) begin
            if (offs == 12'(irq_pkg::plic_prio_base + 4 * s)) begin
                bus_i.rdata = 32'(prio_q[s]);
            end
        end
        for (int t = 0; t < irq_pkg::num_targets; t++) begin
            if (offs == 12'(irq_pkg::plic_enable_base + 4 * t)) begin
                bus_i.rdata = {29'd0, enable_q[t], 1'b0};
            end
            if (offs == 12'(irq_pkg::plic_target_base + irq_pkg::plic_target_stride * t)) begin
                bus_i.rdata = 32'(threshold_q[t]);
            end
            if (offs == 12'(irq_pkg::plic_target_base + irq_pkg::plic_target_stride * t + 4)) begin
                bus_i.rdata = 32'(best_id[t]);
                for (int s = 1; s <= irq_pkg::num_sources; s++) begin
                    claim_mask[s]    = rd && (best_id[t] == irq_pkg::src_id_t'(s));
                    complete_mask[s] = wr && (bus_i.wdata == 32'(s));
                end
            end
        end
    end

    assign bus_i.error = 1'b0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q  <= '0;
            inflight_q <= '0;
            irq_o      <= '0;
            for (int s = 1; s <= irq_pkg::num_sources; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < irq_pkg::num_targets; t++) begin
                enable_q[t]    <= '0;
                threshold_q[t] <= '0;
            end
        end else begin
            // Gateways, a claim pulls the source out of pending
            pending_q  <= (pending_q | (src_lvl & ~inflight_q)) & ~claim_mask;
            inflight_q <= (inflight_q | claim_mask) & ~complete_mask;
            irq_o      <= irq_d;
            for (int s = 1; s <= irq_pkg::num_sources; s++) begin
                if (wr && offs == 12'(irq_pkg::plic_prio_base + 4 * s)) begin
                    prio_q[s] <= bus_i.wdata[irq_pkg::prio_width-1:0];
                end
            end
            for (int t = 0; t < irq_pkg::num_targets; t++) begin
                if (wr && offs == 12'(irq_pkg::plic_enable_base + 4 * t)) begin
                    enable_q[t] <= bus_i.wdata[irq_pkg::num_sources:1];
                end
                if (wr && offs == 12'(irq_pkg::plic_target_base
                                      + irq_pkg::plic_target_stride * t)) begin
                    threshold_q[t] <= bus_i.wdata[irq_pkg::prio_width-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/periph_subsys.sv */
// Peripheral subsystem top level
// APB slave port in front of a compare timer and a two-target PLIC
`timescale 1ns/1ps
`default_nettype none

module periph_subsys (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  periph_pkg::reg_addr_t           paddr_i,
    input  periph_pkg::reg_data_t           pwdata_i,
    output periph_pkg::reg_data_t           prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic [irq_pkg::num_targets-1:0] irq_o
);

    // Timer channel i drives PLIC source i+1
    logic [irq_pkg::num_sources-1:0] irq_src;

    reg_bus_if bus_in ();
    reg_bus_if bus_tmr ();
    reg_bus_if bus_plic ();

    apb_reg_bridge apb_reg_bridge_i (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .bus_o     ( bus_in    )
    );

    reg_decoder reg_decoder_i (
        .bus_i  ( bus_in   ),
        .tmr_o  ( bus_tmr  ),
        .plic_o ( bus_plic )
    );

    timer_unit timer_unit_i (
        .clk_i     ( clk_i   ),
        .rst_i     ( rst_i   ),
        .bus_i     ( bus_tmr ),
        .irq_src_o ( irq_src )
    );

    plic_core plic_core_i (
        .clk_i     ( clk_i    ),
        .rst_i     ( rst_i    ),
        .bus_i     ( bus_plic ),
        .irq_src_i ( irq_src  ),
        .irq_o     ( irq_o    )
    );

endmodule

`default_nettype wire

/* verif/periph_subsys_assertions.sv */
// Protocol and reset assertions for the peripheral subsystem
`timescale 1ns/1ps
`default_nettype none

module periph_subsys_assertions (
    input logic                            clk_i,
    input logic                            rst_i,
    input logic                            pready_i,
    input logic                            pslverr_i,
    input logic [irq_pkg::num_targets-1:0] irq_i
);

    int unsigned fail_count;

    initial fail_count = 0;

    pready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        pready_i |=> !pready_i)
        else begin
            fail_count++;
            $error("pready_o high for more than one cycle");
        end

    slverr_with_ready: assert property (@(posedge clk_i) pslverr_i |-> pready_i)
        else begin
            fail_count++;
            $error("pslverr_o high without pready_o");
        end

    // Reset clears the target lines at the first reset edge
    irq_in_reset: assert property (@(posedge clk_i) rst_i |=> (irq_i == '0))
        else begin
            fail_count++;
            $error("irq_o not 0 during reset");
        end

endmodule

bind periph_subsys periph_subsys_assertions periph_subsys_assertions_i (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .pready_i  ( pready_o  ),
    .pslverr_i ( pslverr_o ),
    .irq_i     ( irq_o     )
);

`default_nettype wire

/* verif/periph_checker.sv */
// Response checker
// Compares APB read data, error flags and interrupt levels with the
// values the testbench expects and counts mismatches
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            pready_i,
    input  logic                            pslverr_i,
    input  periph_pkg::reg_data_t           prdata_i,
    input  logic [irq_pkg::num_targets-1:0] irq_i,
    input  logic                            apb_check_i,
    input  logic                            apb_read_i,
    input  periph_pkg::reg_data_t           exp_rdata_i,
    input  logic                            exp_err_i,
    input  logic                            irq_check_i,
    input  logic                            irq_tgt_i,
    input  logic                            exp_irq_i,
    output logic                            irq_hit_o,
    output int                              error_count_o
);

    int errors;

    assign irq_hit_o     = (irq_i[irq_tgt_i] === exp_irq_i);
    assign error_count_o = errors;

    always @(posedge clk_i) begin
        if (rst_i) begin
            errors = 0;
        end else begin
            // Completion cycle of an APB transfer
            if (pready_i && !apb_check_i) begin
                $display("Unexpected pready_o at %0t with no transfer in progress", $time);
                errors = errors + 1;
            end
            if (pready_i && apb_check_i) begin
                if (pslverr_i !== exp_err_i) begin
                    $display("Fail at %0t: pslverr_o is %0b, expected %0b",
                             $time, pslverr_i, exp_err_i);
                    errors = errors + 1;
                end
                if (apb_read_i && prdata_i !== exp_rdata_i) begin
                    $display("Fail at %0t: prdata_o is 0x%08h, expected 0x%08h",
                             $time, prdata_i, exp_rdata_i);
                    errors = errors + 1;
                end
            end
            if (irq_check_i && irq_i[irq_tgt_i] !== exp_irq_i) begin
                $display("Fail at %0t: irq_o[%0d] is %0b, expected to stay %0b",
                         $time, irq_tgt_i, irq_i[irq_tgt_i], exp_irq_i);
                errors = errors + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/periph_subsys_tb.sv */
// Peripheral subsystem testbench
// Reads APB accesses and interrupt waits from a command file and
// hands the expected values to the checker
`timescale 1ns/1ps
`default_nettype none

module periph_subsys_tb;

    localparam int apb_timeout = 20;

    logic                            clk;
    logic                            rst;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    periph_pkg::reg_addr_t           paddr;
    periph_pkg::reg_data_t           pwdata;
    periph_pkg::reg_data_t           prdata;
    logic                            pready;
    logic                            pslverr;
    logic [irq_pkg::num_targets-1:0] irq;

    // Expected values for the checker
    logic                            apb_check;
    logic                            apb_read;
    periph_pkg::reg_data_t           exp_rdata;
    logic                            exp_err;
    logic                            irq_check;
    logic                            irq_tgt;
    logic                            exp_irq;
    logic                            irq_hit;
    int                              check_errors;
    int                              timeouts;
    int                              other_errors;
    logic [31:0]                     rng_state;

    periph_subsys periph_subsys_i (
        .clk_i     ( clk     ),
        .rst_i     ( rst     ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .irq_o     ( irq     )
    );

    periph_checker periph_checker_i (
        .clk_i         ( clk          ),
        .rst_i         ( rst          ),
        .pready_i      ( pready       ),
        .pslverr_i     ( pslverr      ),
        .prdata_i      ( prdata       ),
        .irq_i         ( irq          ),
        .apb_check_i   ( apb_check    ),
        .apb_read_i    ( apb_read     ),
        .exp_rdata_i   ( exp_rdata    ),
        .exp_err_i     ( exp_err      ),
        .irq_check_i   ( irq_check    ),
        .irq_tgt_i     ( irq_tgt      ),
        .exp_irq_i     ( exp_irq      ),
        .irq_hit_o     ( irq_hit      ),
        .error_count_o ( check_errors )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Setup cycle, then access until pready
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic err);
        int waited;
        @(negedge clk);
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = write;
        paddr     = addr;
        pwdata    = write ? data : 32'd0;
        apb_check = 1'b1;
        apb_read  = ~write;
        exp_rdata = data;
        exp_err   = err;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!pready && waited < apb_timeout);
        if (!pready) begin
            $display("No pready within %0d cycles for access to 0x%08h", apb_timeout, addr);
            timeouts++;
        end
        @(negedge clk);
        psel      = 1'b0;
        penable   = 1'b0;
        apb_check = 1'b0;
    endtask

    task automatic wait_irq(input logic tgt, input logic level, input int limit);
        int waited;
        @(negedge clk);
        irq_tgt = tgt;
        exp_irq = level;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!irq_hit && waited < limit);
        if (!irq_hit) begin
            $display("irq_o[%0d] did not reach %0b within %0d cycles", tgt, level, limit);
            timeouts++;
        end
    endtask

    // Checker compares the level on every edge of the window
    task automatic hold_irq(input logic tgt, input logic level, input int cycles);
        @(negedge clk);
        irq_tgt   = tgt;
        exp_irq   = level;
        irq_check = 1'b1;
        repeat (cycles) @(negedge clk);
        irq_check = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          f3;
        int          gap;
        int          total;
        int          assert_fails;
        string       line;
        byte         cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        apb_check    = 1'b0;
        apb_read     = 1'b0;
        exp_rdata    = '0;
        exp_err      = 1'b0;
        irq_check    = 1'b0;
        irq_tgt      = 1'b0;
        exp_irq      = 1'b0;
        timeouts     = 0;
        other_errors = 0;
        rng_state    = 32'd45543;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verif/periph_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file verif/periph_tests.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 2 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %d", cmd, f1, f2, f3);
                    if (n != 4) begin
                        $display("Malformed command line: %s", line);
                        other_errors++;
                    end else begin
                        case (cmd)
                            "W": apb_transfer(1'b1, f1, f2, f3[0]);
                            "R": apb_transfer(1'b0, f1, f2, f3[0]);
                            "I": wait_irq(f1[0], f2[0], f3);
                            "H": hold_irq(f1[0], f2[0], f3);
                            default: begin
                                $display("Unknown command %c in command file", cmd);
                                other_errors++;
                            end
                        endcase
                        rng_state = xorshift32(rng_state);
                        gap       = int'(rng_state[1:0]);
                        repeat (gap) @(negedge clk);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (2) @(negedge clk);
        assert_fails = int'(periph_subsys_i.periph_subsys_assertions_i.fail_count);
        total = check_errors + timeouts + other_errors + assert_fails;
        $display("Errors: %0d compare, %0d timeout, %0d other, %0d assertion",
                 check_errors, timeouts, other_errors, assert_fails);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/periph_tests.txt */
# Columns: cmd, addr or target (hex), data or level (hex), error or cycles (decimal)
# W write, R read with expected data, I wait for irq level, H irq level held for cycles
# Reset values of timer 0 and timer 1
R 00000000 00000000 0
R 00000004 00000000 0
R 0000000C 00000000 0
R 0000001C 00000000 0
W 00000008 12345678 0
R 00000008 12345678 0
W 00000018 0000ABCD 0
R 00000018 0000ABCD 0
# Unmapped region, timer registers untouched
W 00003000 11111111 1
R 00003000 DEADBEEF 1
R 00000000 00000000 0
R 00000008 12345678 0
# Timer 0 on source 1, routed to target 0
W 00000008 00000014 0
W 00001004 00000003 0
W 00001080 00000002 0
W 00000000 00000003 0
I 0 1 40
H 1 0 10
R 0000000C 00000001 0
# Claim and complete on target 0
R 00001104 00000001 0
W 00000000 00000000 0
W 0000000C 00000001 0
W 00001104 00000001 0
I 0 0 10
H 0 0 30
# Both timers on target 1, source 2 ahead of source 1
W 00001080 00000000 0
W 00001008 00000005 0
W 00001004 00000002 0
W 00001084 00000006 0
W 00000018 0000000A 0
W 00000010 00000003 0
W 00000000 00000003 0
I 1 1 40
H 1 1 30
R 00001114 00000002 0
R 00001114 00000001 0
# Threshold 5 masks source 2
W 00001110 00000005 0
W 00001114 00000002 0
H 1 0 20
R 00001114 00000000 0
W 00001110 00000004 0
I 1 1 10

/* flist.f */
source/periph_pkg.sv
source/irq_pkg.sv
source/reg_bus_if.sv
source/apb_reg_bridge.sv
source/reg_decoder.sv
source/timer_unit.sv
source/plic_core.sv
source/periph_subsys.sv
verif/periph_subsys_assertions.sv
verif/periph_checker.sv
verif/periph_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_subsys_tb \
    -f flist.f -Mdir obj_dir -o periph_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/periph_subsys_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
